// File: verilog/serial_pkg.sv
`default_nettype none

package serial_pkg;

   // Word and bit counter widths
   localparam int XLEN  = 32;
   localparam int CNT_W = 5;

   // Major opcodes, instruction bits 6:2
   localparam logic [4:0] OPC_OP    = 5'b01100;
   localparam logic [4:0] OPC_OPIMM = 5'b00100;
   localparam logic [4:0] OPC_LUI   = 5'b01101;

   localparam logic [2:0] F3_ADD  = 3'b000;
   localparam logic [2:0] F3_SLT  = 3'b010;
   localparam logic [2:0] F3_SLTU = 3'b011;
   localparam logic [2:0] F3_XOR  = 3'b100;
   localparam logic [2:0] F3_OR   = 3'b110;
   localparam logic [2:0] F3_AND  = 3'b111;

   typedef struct packed {
      logic [6:0] funct7;
      logic [4:0] rs2;
      logic [4:0] rs1;
      logic [2:0] funct3;
      logic [4:0] rd;
      logic [6:0] opcode;
   } r_fmt_t;

   typedef struct packed {
      logic [11:0] imm12;
      logic [4:0]  rs1;
      logic [2:0]  funct3;
      logic [4:0]  rd;
      logic [6:0]  opcode;
   } i_fmt_t;

   typedef struct packed {
      logic [19:0] imm20;
      logic [4:0]  rd;
      logic [6:0]  opcode;
   } u_fmt_t;

   // Same 32-bit word seen as R, I or U format
   typedef union packed {
      r_fmt_t r_fmt;
      i_fmt_t i_fmt;
      u_fmt_t u_fmt;
   } instr_u;

   // Source of the rd bit stream
   typedef enum logic [1:0] {
      RD_ADD  = 2'd0,
      RD_BOOL = 2'd1,
      RD_LT   = 2'd2,
      RD_IMM  = 2'd3
   } rd_sel_e;

   // Encoded as funct3[1:0]
   typedef enum logic [1:0] {
      BOOL_XOR = 2'b00,
      BOOL_OR  = 2'b10,
      BOOL_AND = 2'b11
   } bool_op_e;

endpackage

`default_nettype wire

// File: verilog/decode_if.sv
`timescale 1ns/1ps
`default_nettype none

interface decode_if;

   logic                 legal;
   serial_pkg::rd_sel_e  rd_sel;
   logic                 alu_sub;
   logic                 cmp_uns;
   serial_pkg::bool_op_e bool_op;
   logic                 op_b_imm;

   // Current immediate bit, rotates once per execute cycle
   logic                 imm_bit;

   logic [4:0]           rs1_addr;
   logic [4:0]           rs2_addr;
   logic [4:0]           rd_addr;

   modport dec (
      output legal, rd_sel, alu_sub, cmp_uns, bool_op, op_b_imm,
      output imm_bit,
      output rs1_addr, rs2_addr, rd_addr
   );

   modport ctl (input legal, rd_sel);

   modport alu (input rd_sel, alu_sub, cmp_uns, bool_op, op_b_imm, imm_bit);

   modport rf (input rs1_addr, rs2_addr, rd_addr);

endinterface

`default_nettype wire

// File: verilog/instr_decode.sv
`timescale 1ns/1ps
`default_nettype none

module instr_decode (
   input  logic               clk,
   input  logic               i_ibus_ack,
   input  serial_pkg::instr_u i_ibus_rdt,
   input  logic               i_cnt_en,
   decode_if.dec              d
);

   serial_pkg::instr_u          instr;
   logic [serial_pkg::XLEN-1:0] imm;
   logic [4:0]                  rdt_opc;
   logic [4:0]                  opc;
   logic [2:0]                  funct3;
   logic [6:0]                  funct7;
   logic                        quad_ok;
   logic                        is_op;
   logic                        is_opimm;
   logic                        is_lui;
   logic                        is_lt;
   logic                        f3_ok;
   logic                        f7_ok;

   assign rdt_opc = i_ibus_rdt.u_fmt.opcode[6:2];

   // Immediate is built from the incoming word so bit 0 is ready on the first execute cycle
   always_ff @(posedge clk) begin
      if (i_ibus_ack) begin
         instr <= i_ibus_rdt;
         if (rdt_opc == serial_pkg::OPC_LUI)
            imm <= {i_ibus_rdt.u_fmt.imm20, 12'd0};
         else
            imm <= {{20{i_ibus_rdt.i_fmt.imm12[11]}}, i_ibus_rdt.i_fmt.imm12};
      end else if (i_cnt_en) begin
         imm <= {imm[0], imm[serial_pkg::XLEN-1:1]};
      end
   end

   assign d.imm_bit = imm[0];

   // Field views of the latched word
   assign opc      = instr.i_fmt.opcode[6:2];
   assign quad_ok  = (instr.u_fmt.opcode[1:0] == 2'b11);
   assign funct3   = instr.i_fmt.funct3;
   assign funct7   = instr.r_fmt.funct7;

   assign d.rs1_addr = instr.i_fmt.rs1;
   assign d.rs2_addr = instr.r_fmt.rs2;
   assign d.rd_addr  = instr.u_fmt.rd;

   assign is_op    = (opc == serial_pkg::OPC_OP);
   assign is_opimm = (opc == serial_pkg::OPC_OPIMM);
   assign is_lui   = (opc == serial_pkg::OPC_LUI);
   assign is_lt    = (funct3 == serial_pkg::F3_SLT) || (funct3 == serial_pkg::F3_SLTU);

   // Shift encodings are not supported
   assign f3_ok = (funct3 != 3'b001) && (funct3 != 3'b101);

   // Only sub may set funct7 bit 30
   assign f7_ok = (funct7 == 7'd0) ||
                  ((funct7 == 7'b0100000) && (funct3 == serial_pkg::F3_ADD));

   assign d.legal = quad_ok &&
                    (is_lui || (is_opimm && f3_ok) || (is_op && f3_ok && f7_ok));

   always_comb begin
      if (is_lui)
         d.rd_sel = serial_pkg::RD_IMM;
      else if (funct3 == serial_pkg::F3_ADD)
         d.rd_sel = serial_pkg::RD_ADD;
      else if (is_lt)
         d.rd_sel = serial_pkg::RD_LT;
      else
         d.rd_sel = serial_pkg::RD_BOOL;
   end

   always_comb begin
      case (funct3)
         serial_pkg::F3_XOR: d.bool_op = serial_pkg::BOOL_XOR;
         serial_pkg::F3_OR:  d.bool_op = serial_pkg::BOOL_OR;
         serial_pkg::F3_AND: d.bool_op = serial_pkg::BOOL_AND;
         default:            d.bool_op = serial_pkg::BOOL_XOR;
      endcase
   end

   // Compares run as a subtraction
   assign d.alu_sub  = (is_op && funct7[5]) || is_lt;
   assign d.cmp_uns  = (funct3 == serial_pkg::F3_SLTU);
   assign d.op_b_imm = !is_op;

   // A new word must not arrive while the old one is still executing
   a_no_ack_in_exec : assert property (@(posedge clk) !(i_ibus_ack && i_cnt_en));

endmodule

`default_nettype wire

// File: verilog/exec_state.sv
`timescale 1ns/1ps
`default_nettype none

module exec_state (
   input  logic  clk,
   input  logic  i_reset,
   input  logic  i_ibus_ack,
   input  logic  i_cnt_last,
   decode_if.ctl d,
   output logic  o_ibus_cyc,
   output logic  o_cnt_en,
   output logic  o_slt_wr,
   output logic  o_retire,
   output logic  o_trap
);

   typedef enum logic [2:0] {
      FETCH,
      DECODE,
      EXEC,
      SLT_WB,
      RETIRE
   } state_e;

   state_e state;
   state_e state_nxt;

   always_ff @(posedge clk) begin
      if (i_reset)
         state <= FETCH;
      else
         state <= state_nxt;
   end

   always_comb begin
      state_nxt = state;
      case (state)
         FETCH:
            if (i_ibus_ack)
               state_nxt = DECODE;
         // Bit 0 already runs here for a legal word
         DECODE:
            state_nxt = d.legal ? EXEC : FETCH;
         EXEC:
            if (i_cnt_last)
               state_nxt = (d.rd_sel == serial_pkg::RD_LT) ? SLT_WB : RETIRE;
         SLT_WB:
            state_nxt = RETIRE;
         RETIRE:
            state_nxt = FETCH;
         default:
            state_nxt = FETCH;
      endcase
   end

   assign o_ibus_cyc = (state == FETCH);
   assign o_cnt_en   = (state == EXEC) || ((state == DECODE) && d.legal);
   assign o_slt_wr   = (state == SLT_WB);
   assign o_retire   = (state == RETIRE);

   // Illegal word is reported straight from decode
   assign o_trap     = (state == DECODE) && !d.legal;

   // The counter reaches bit 31 only inside an execute pass
   a_last_in_exec : assert property (
      @(posedge clk) disable iff (i_reset) i_cnt_last |-> (state == EXEC));

endmodule

`default_nettype wire

// File: verilog/bit_counter.sv
`timescale 1ns/1ps
`default_nettype none

module bit_counter (
   input  logic                         clk,
   input  logic                         i_reset,
   input  logic                         i_cnt_en,
   output logic [serial_pkg::CNT_W-1:0] o_cnt,
   output logic                         o_cnt_last
);

   logic [serial_pkg::CNT_W-1:0] cnt;

   // Wraps to 0 after bit 31
   always_ff @(posedge clk) begin
      if (i_reset)
         cnt <= '0;
      else if (i_cnt_en)
         cnt <= cnt + 1'b1;
   end

   assign o_cnt      = cnt;
   assign o_cnt_last = &cnt;

   // Every execute pass must start at bit 0
   a_start_at_zero : assert property (
      @(posedge clk) disable iff (i_reset) $rose(i_cnt_en) |-> (cnt == '0));

endmodule

`default_nettype wire

// File: verilog/serial_alu.sv
`timescale 1ns/1ps
`default_nettype none

module serial_alu (
   input  logic  clk,
   input  logic  i_cnt_en,
   input  logic  i_cnt0,
   input  logic  i_rs1_bit,
   input  logic  i_rs2_bit,
   input  logic  i_slt_wr,
   decode_if.alu d,
   output logic  o_rd_bit,
   output logic  o_lt
);

   logic op_b_raw;
   logic op_b;
   logic carry_in;
   logic carry_q;
   logic carry_out;
   logic sum_bit;
   logic bool_bit;
   logic lt_nxt;
   logic lt_q;

   assign op_b_raw = d.op_b_imm ? d.imm_bit : i_rs2_bit;

   // Subtract is a + ~b + 1
   assign op_b     = op_b_raw ^ d.alu_sub;
   assign carry_in = i_cnt0 ? d.alu_sub : carry_q;

   assign sum_bit   = i_rs1_bit ^ op_b ^ carry_in;
   assign carry_out = (i_rs1_bit & op_b) | (carry_in & (i_rs1_bit ^ op_b));

   always_comb begin
      case (d.bool_op)
         serial_pkg::BOOL_OR:  bool_bit = i_rs1_bit | op_b_raw;
         serial_pkg::BOOL_AND: bool_bit = i_rs1_bit & op_b_raw;
         default:              bool_bit = i_rs1_bit ^ op_b_raw;
      endcase
   end

   // Final value comes from bit 31 of the difference
   // signed: sign xor overflow, unsigned: borrow out
   assign lt_nxt = d.cmp_uns ? !carry_out : (sum_bit ^ carry_in ^ carry_out);

   always_ff @(posedge clk) begin
      if (i_cnt_en) begin
         carry_q <= carry_out;
         lt_q    <= lt_nxt;
      end
   end

   assign o_lt = lt_q;

   always_comb begin
      if (i_slt_wr) begin
         o_rd_bit = lt_q;
      end else begin
         case (d.rd_sel)
            serial_pkg::RD_ADD:  o_rd_bit = sum_bit;
            serial_pkg::RD_BOOL: o_rd_bit = bool_bit;
            // Upper bits of a compare result are zero
            serial_pkg::RD_LT:   o_rd_bit = 1'b0;
            default:             o_rd_bit = d.imm_bit;
         endcase
      end
   end

endmodule

`default_nettype wire

// File: verilog/serial_regfile.sv
`timescale 1ns/1ps
`default_nettype none

module serial_regfile (
   input  logic                         clk,
   input  logic [serial_pkg::CNT_W-1:0] i_cnt,
   input  logic                         i_cnt_en,
   input  logic                         i_slt_wr,
   input  logic                         i_rd_bit,
   input  logic                         i_retire,
   decode_if.rf                         d,
   output logic                         o_rs1_bit,
   output logic                         o_rs2_bit,
   output logic [serial_pkg::XLEN-1:0]  o_retire_data
);

   logic [serial_pkg::XLEN-1:0]  regs [32];
   logic [serial_pkg::XLEN-1:0]  word_sr;
   logic [serial_pkg::CNT_W-1:0] wr_idx;
   logic                         rd_nonzero;
   logic                         wr_en;

   assign rd_nonzero = (d.rd_addr != 5'd0);

   // x0 reads as zero
   assign o_rs1_bit = (d.rs1_addr != 5'd0) && regs[d.rs1_addr][i_cnt];
   assign o_rs2_bit = (d.rs2_addr != 5'd0) && regs[d.rs2_addr][i_cnt];

   // Compare result lands in bit 0 after the execute pass
   assign wr_idx = i_slt_wr ? '0 : i_cnt;
   assign wr_en  = (i_cnt_en || i_slt_wr) && rd_nonzero;

   always_ff @(posedge clk) begin
      if (wr_en)
         regs[d.rd_addr][wr_idx] <= i_rd_bit;
   end

   // Retire word, shifted in LSB first
   always_ff @(posedge clk) begin
      if (i_cnt_en)
         word_sr <= {i_rd_bit, word_sr[serial_pkg::XLEN-1:1]};
      else if (i_slt_wr)
         word_sr[0] <= i_rd_bit;
   end

   assign o_retire_data = (i_retire && rd_nonzero) ? word_sr : '0;

   // Writeback of a compare result is its own cycle
   a_slt_wr_excl : assert property (@(posedge clk) !(i_slt_wr && i_cnt_en));

endmodule

`default_nettype wire

// File: verilog/serial_core.sv
`timescale 1ns/1ps
`default_nettype none

module serial_core (
   input  logic        clk,
   input  logic        i_reset,
   output logic        o_ibus_cyc,
   input  logic        i_ibus_ack,
   input  logic [31:0] i_ibus_rdt,
   output logic        o_retire,
   output logic [4:0]  o_retire_rd,
   output logic [31:0] o_retire_data,
   output logic        o_trap
);

   logic                         cnt_en;
   logic                         cnt_last;
   logic [serial_pkg::CNT_W-1:0] cnt;
   logic                         cnt0;
   logic                         slt_wr;
   logic                         retire;
   logic                         rs1_bit;
   logic                         rs2_bit;
   logic                         rd_bit;

   decode_if dec_bus ();

   assign cnt0        = (cnt == '0);
   assign o_retire    = retire;
   assign o_retire_rd = dec_bus.rd_addr;

   instr_decode instr_decode_inst (
      .clk        (clk),
      .i_ibus_ack (i_ibus_ack),
      .i_ibus_rdt (i_ibus_rdt),
      .i_cnt_en   (cnt_en),
      .d          (dec_bus.dec)
   );

   exec_state exec_state_inst (
      .clk        (clk),
      .i_reset    (i_reset),
      .i_ibus_ack (i_ibus_ack),
      .i_cnt_last (cnt_last),
      .d          (dec_bus.ctl),
      .o_ibus_cyc (o_ibus_cyc),
      .o_cnt_en   (cnt_en),
      .o_slt_wr   (slt_wr),
      .o_retire   (retire),
      .o_trap     (o_trap)
   );

   bit_counter bit_counter_inst (
      .clk        (clk),
      .i_reset    (i_reset),
      .i_cnt_en   (cnt_en),
      .o_cnt      (cnt),
      .o_cnt_last (cnt_last)
   );

   // Compare flag only feeds the rd bit stream
   serial_alu serial_alu_inst (
      .clk       (clk),
      .i_cnt_en  (cnt_en),
      .i_cnt0    (cnt0),
      .i_rs1_bit (rs1_bit),
      .i_rs2_bit (rs2_bit),
      .i_slt_wr  (slt_wr),
      .d         (dec_bus.alu),
      .o_rd_bit  (rd_bit),
      .o_lt      ()
   );

   serial_regfile serial_regfile_inst (
      .clk           (clk),
      .i_cnt         (cnt),
      .i_cnt_en      (cnt_en),
      .i_slt_wr      (slt_wr),
      .i_rd_bit      (rd_bit),
      .i_retire      (retire),
      .d             (dec_bus.rf),
      .o_rs1_bit     (rs1_bit),
      .o_rs2_bit     (rs2_bit),
      .o_retire_data (o_retire_data)
   );

endmodule

`default_nettype wire

// File: test/tb_serial_core.sv
`timescale 1ns/1ps
`default_nettype none

module tb_serial_core;

   localparam int CLK_PERIOD = 4;
   localparam int MAX_DELAY  = 3;

   // Instruction counts of the six test groups
   localparam int N_INIT     = 62;
   localparam int N_ARITH    = 40;
   localparam int N_BOOL     = 30;
   localparam int N_CMP      = 69;
   localparam int N_X0       = 5;
   localparam int N_ILLEGAL  = 9;
   localparam int N_INSTR    = N_INIT + N_ARITH + N_BOOL + N_CMP + N_X0 + N_ILLEGAL;

   // At most 40 cycles per instruction plus the ack delay
   localparam int TIMEOUT_NS = (N_INSTR * (40 + MAX_DELAY) + 200) * CLK_PERIOD;

   localparam logic [2:0]  BOOL_F3 [3] = '{serial_pkg::F3_XOR, serial_pkg::F3_OR,
                                           serial_pkg::F3_AND};
   localparam logic [11:0] CMP_IMM [4] = '{12'h000, 12'hfff, 12'h7ff, 12'h800};

   typedef struct packed {
      logic                        legal;
      logic [4:0]                  rd;
      logic [serial_pkg::XLEN-1:0] data;
   } result_t;

   logic        clk;
   logic        i_reset;
   logic        o_ibus_cyc;
   logic        i_ibus_ack;
   logic [31:0] i_ibus_rdt;
   logic        o_retire;
   logic [4:0]  o_retire_rd;
   logic [31:0] o_retire_data;
   logic        o_trap;

   logic [serial_pkg::XLEN-1:0] shadow [32];
   result_t                     expected_q [$];
   integer                      seed;
   int                          n_checked;

   // Fetch request level expected from the strobes seen so far
   logic                        fetch_exp;

   serial_core serial_core_inst (
      .clk           (clk),
      .i_reset       (i_reset),
      .o_ibus_cyc    (o_ibus_cyc),
      .i_ibus_ack    (i_ibus_ack),
      .i_ibus_rdt    (i_ibus_rdt),
      .o_retire      (o_retire),
      .o_retire_rd   (o_retire_rd),
      .o_retire_data (o_retire_data),
      .o_trap        (o_trap)
   );

   always #(CLK_PERIOD / 2) clk = ~clk;

   task automatic abort_run(input string reason);
      $display("%s", reason);
      $display("*** TEST FAILED ***");
      $fatal(1, "Simulation stopped on the first failure");
   endtask

   task automatic check_word(input logic [serial_pkg::XLEN-1:0] got,
                             input logic [serial_pkg::XLEN-1:0] exp);
      if (got !== exp)
         abort_run($sformatf("Error at %0t ns: o_retire_data got 0x%08h expected 0x%08h",
                             $time, got, exp));
   endtask

   task automatic check_rd(input logic [4:0] got, input logic [4:0] exp);
      if (got !== exp)
         abort_run($sformatf("Error at %0t ns: o_retire_rd got %0d expected %0d",
                             $time, got, exp));
   endtask

   task automatic check_cyc(input logic got, input logic exp);
      if (got !== exp)
         abort_run($sformatf("Error at %0t ns: o_ibus_cyc got %0b expected %0b",
                             $time, got, exp));
   endtask

   task automatic check_trap(input logic exp_legal, input logic got_trap);
      if (exp_legal && got_trap)
         abort_run($sformatf("Trap at %0t ns for an instruction that should retire", $time));
      else if (!exp_legal && !got_trap)
         abort_run($sformatf("Retire at %0t ns for an instruction that should trap", $time));
   endtask

   // Expected rd word and legality from the ISA rules
   function automatic logic [serial_pkg::XLEN-1:0] ref_exec(
      input  serial_pkg::instr_u          w,
      input  logic [serial_pkg::XLEN-1:0] regs [32],
      output logic                        legal);
      logic [4:0]                  opc;
      logic [2:0]                  f3;
      logic [6:0]                  f7;
      logic [serial_pkg::XLEN-1:0] a;
      logic [serial_pkg::XLEN-1:0] b;
      logic [serial_pkg::XLEN-1:0] res;
      opc = w.r_fmt.opcode[6:2];
      f3  = w.r_fmt.funct3;
      f7  = w.r_fmt.funct7;
      a   = regs[w.r_fmt.rs1];
      if (opc == serial_pkg::OPC_OP)
         b = regs[w.r_fmt.rs2];
      else
         b = {{20{w.i_fmt.imm12[11]}}, w.i_fmt.imm12};
      case (opc)
         serial_pkg::OPC_LUI:   legal = 1'b1;
         serial_pkg::OPC_OPIMM: legal = (f3 != 3'b001) && (f3 != 3'b101);
         serial_pkg::OPC_OP:    legal = (f3 != 3'b001) && (f3 != 3'b101) &&
                                        ((f7 == 7'h00) ||
                                         ((f7 == 7'h20) && (f3 == serial_pkg::F3_ADD)));
         default:               legal = 1'b0;
      endcase
      if (w.r_fmt.opcode[1:0] != 2'b11)
         legal = 1'b0;
      case (f3)
         serial_pkg::F3_ADD:  res = ((opc == serial_pkg::OPC_OP) && f7[5]) ? a - b : a + b;
         serial_pkg::F3_SLT:  res = {31'd0, $signed(a) < $signed(b)};
         serial_pkg::F3_SLTU: res = {31'd0, a < b};
         serial_pkg::F3_XOR:  res = a ^ b;
         serial_pkg::F3_OR:   res = a | b;
         default:             res = a & b;
      endcase
      if (opc == serial_pkg::OPC_LUI)
         res = {w.u_fmt.imm20, 12'd0};
      return res;
   endfunction

   function automatic serial_pkg::instr_u make_r(input logic [6:0] f7, input logic [4:0] rs2,
                                                 input logic [4:0] rs1, input logic [2:0] f3,
                                                 input logic [4:0] rd);
      serial_pkg::instr_u w;
      w.r_fmt = '{f7, rs2, rs1, f3, rd, {serial_pkg::OPC_OP, 2'b11}};
      return w;
   endfunction

   function automatic serial_pkg::instr_u make_i(input logic [11:0] imm, input logic [4:0] rs1,
                                                 input logic [2:0] f3, input logic [4:0] rd);
      serial_pkg::instr_u w;
      w.i_fmt = '{imm, rs1, f3, rd, {serial_pkg::OPC_OPIMM, 2'b11}};
      return w;
   endfunction

   function automatic serial_pkg::instr_u make_u(input logic [19:0] imm, input logic [4:0] rd);
      serial_pkg::instr_u w;
      w.u_fmt = '{imm, rd, {serial_pkg::OPC_LUI, 2'b11}};
      return w;
   endfunction

   // Any of x1 to x31
   function automatic logic [4:0] rand_reg();
      return 5'd1 + 5'($unsigned($random(seed)) % 31);
   endfunction

   // Queue the expected result, then hand the word over on the fetch bus
   task automatic issue(input serial_pkg::instr_u w);
      result_t                     e;
      logic [serial_pkg::XLEN-1:0] value;
      logic                        legal;
      int                          delay;
      value   = ref_exec(w, shadow, legal);
      e.legal = legal;
      e.rd    = w.r_fmt.rd;
      e.data  = (w.r_fmt.rd == 5'd0) ? '0 : value;
      if (legal && (w.r_fmt.rd != 5'd0))
         shadow[w.r_fmt.rd] = value;
      expected_q.push_back(e);
      delay = $unsigned($random(seed)) % (MAX_DELAY + 1);
      @(posedge clk);
      while (!o_ibus_cyc)
         @(posedge clk);
      repeat (delay)
         @(posedge clk);
      i_ibus_ack <= 1'b1;
      i_ibus_rdt <= w;
      @(posedge clk);
      i_ibus_ack <= 1'b0;
   endtask

   // Every retire or trap pulse is matched against the oldest queued result
   always @(posedge clk) begin
      result_t e;
      if (i_reset) begin
         fetch_exp = 1'b1;
      end else begin
         check_cyc(o_ibus_cyc, fetch_exp);
         if (i_ibus_ack)
            fetch_exp = 1'b0;
         if (o_retire || o_trap) begin
            if (expected_q.size() == 0) begin
               abort_run($sformatf("Result strobe at %0t ns with nothing outstanding", $time));
            end else begin
               e = expected_q.pop_front();
               check_trap(e.legal, o_trap);
               if (o_retire) begin
                  check_rd(o_retire_rd, e.rd);
                  check_word(o_retire_data, e.data);
               end
               n_checked++;
            end
            fetch_exp = 1'b1;
         end
      end
   end

   initial begin
      #(TIMEOUT_NS);
      abort_run($sformatf("Timeout after %0d ns with %0d results still outstanding",
                          TIMEOUT_NS, expected_q.size()));
   end

   initial begin
      serial_pkg::instr_u w;
      seed       = 32'hbdc7_aa81;
      n_checked  = 0;
      fetch_exp  = 1'b1;
      clk        = 1'b0;
      i_reset    = 1'b1;
      i_ibus_ack = 1'b0;
      i_ibus_rdt = '0;
      for (int i = 0; i < 32; i++)
         shadow[i] = '0;
      repeat (2) @(posedge clk);
      i_reset <= 1'b0;

      for (int r = 1; r < 32; r++) begin
         issue(make_u(20'($random(seed)), 5'(r)));
         issue(make_i(12'($random(seed)), 5'(r), serial_pkg::F3_ADD, 5'(r)));
      end

      // Random operands wrap often under add and sub
      for (int i = 0; i < N_ARITH; i++)
         issue(make_r(i[0] ? 7'h20 : 7'h00, rand_reg(), rand_reg(), serial_pkg::F3_ADD,
                      rand_reg()));

      for (int i = 0; i < N_BOOL / 6; i++) begin
         for (int k = 0; k < 3; k++) begin
            issue(make_r(7'h00, rand_reg(), rand_reg(), BOOL_F3[k], rand_reg()));
            issue(make_i(12'($random(seed)) | 12'h800, rand_reg(), BOOL_F3[k], rand_reg()));
         end
      end

      // x1 most negative, x2 most positive, x3 all ones, x4 zero
      issue(make_u(20'h80000, 5'd1));
      issue(make_u(20'h80000, 5'd2));
      issue(make_i(12'hfff, 5'd2, serial_pkg::F3_ADD, 5'd2));
      issue(make_i(12'hfff, 5'd0, serial_pkg::F3_ADD, 5'd3));
      issue(make_r(7'h00, 5'd0, 5'd0, serial_pkg::F3_ADD, 5'd4));
      for (int a = 1; a <= 4; a++) begin
         for (int b = 1; b <= 4; b++) begin
            issue(make_r(7'h00, 5'(b), 5'(a), serial_pkg::F3_SLT, 5'd10));
            issue(make_r(7'h00, 5'(b), 5'(a), serial_pkg::F3_SLTU, 5'd11));
         end
         for (int k = 0; k < 4; k++) begin
            issue(make_i(CMP_IMM[k], 5'(a), serial_pkg::F3_SLT, 5'd12));
            issue(make_i(CMP_IMM[k], 5'(a), serial_pkg::F3_SLTU, 5'd13));
         end
      end

      // x0 as target and then as source
      issue(make_i(12'h123, 5'd5, serial_pkg::F3_ADD, 5'd0));
      issue(make_r(7'h20, 5'd1, 5'd2, serial_pkg::F3_ADD, 5'd0));
      issue(make_u(20'hfffff, 5'd0));
      issue(make_r(7'h00, 5'd0, 5'd0, serial_pkg::F3_OR, 5'd6));
      issue(make_i(12'h005, 5'd0, serial_pkg::F3_XOR, 5'd7));

      // Illegal words aimed at x9 which is read back afterwards
      issue(make_u(20'h5a5a5, 5'd9));
      issue(make_i(12'h001, 5'd9, 3'b001, 5'd9));
      issue(make_i(12'h401, 5'd9, 3'b101, 5'd9));
      issue(make_r(7'h00, 5'd1, 5'd9, 3'b001, 5'd9));
      w = make_r(7'h00, 5'd1, 5'd9, serial_pkg::F3_ADD, 5'd9);
      w.r_fmt.opcode = 7'b1100011;
      issue(w);
      issue(make_r(7'h01, 5'd1, 5'd9, serial_pkg::F3_ADD, 5'd9));
      issue(make_r(7'h20, 5'd1, 5'd9, serial_pkg::F3_XOR, 5'd9));
      w = make_i(12'h00f, 5'd9, serial_pkg::F3_ADD, 5'd9);
      w.r_fmt.opcode[1:0] = 2'b01;
      issue(w);
      issue(make_r(7'h00, 5'd0, 5'd9, serial_pkg::F3_OR, 5'd10));

      while (expected_q.size() != 0)
         @(posedge clk);
      repeat (4) @(posedge clk);
      if (n_checked == N_INSTR) begin
         $display("*** TEST PASSED ***");
         $finish;
      end else begin
         abort_run($sformatf("Only %0d of %0d results were checked", n_checked, N_INSTR));
      end
   end

endmodule

`default_nettype wire

// File: tb.f
verilog/serial_pkg.sv
verilog/decode_if.sv
verilog/instr_decode.sv
verilog/exec_state.sv
verilog/bit_counter.sv
verilog/serial_alu.sv
verilog/serial_regfile.sv
verilog/serial_core.sv
test/tb_serial_core.sv

// File: Makefile
TOP := tb_serial_core

.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal -f tb.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) | awk '{ print } /\*\*\* TEST PASSED \*\*\*/ { ok = 1 } END { exit !ok }'

clean:
	rm -rf obj_dir
